//--- Bender.yml
package:
  name: icache

export_include_dirs:
  - .

sources:
  - files:
      - icache_pkg.sv
      - icache_way.sv
      - icache_refill_ctrl.sv
      - icache_way_select.sv
      - icache_top.sv
  - target: test
    files:
      - icache_tb.sv

//--- icache_defines.svh
// Geometry and address width macros for the instruction cache, included by the package and RTL

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ======================================================================
// Cache geometry
// ======================================================================
`define ICACHE_WAY      2
`define ICACHE_LINE     16
`define ICACHE_WORDS    4

// ======================================================================
// Address and instruction widths
// ======================================================================
`define PC_LENGTH       32
`define INST_LENGTH     32
`define BYTE_OFFSET     2
`define WORD_OFFSET     ($clog2(`ICACHE_WORDS))
`define INDEX_LENGTH    ($clog2(`ICACHE_LINE))

// Whatever is left of the fetch address above index and offsets
`define TAG_LENGTH      (`PC_LENGTH - `INDEX_LENGTH - `WORD_OFFSET - `BYTE_OFFSET)

`endif

//--- icache_pkg.sv
// Shared types of the instruction cache, imported by every RTL module of the cache

`include "icache_defines.svh"

package icache_pkg;

	// Field slices of a fetch address
	typedef logic [`TAG_LENGTH-1:0]    tag_t;
	typedef logic [`INDEX_LENGTH-1:0]  index_t;
	typedef logic [`WORD_OFFSET-1:0]   word_sel_t;
	typedef logic [`INST_LENGTH-1:0]   inst_t;

	// One bit per way
	typedef logic [`ICACHE_WAY-1:0]    way_mask_t;

	// Tag in the upper bits, byte offset at the bottom
	typedef struct packed {
		tag_t                     tag;
		index_t                   index;
		word_sel_t                word;
		logic [`BYTE_OFFSET-1:0]  byte_off;
	} fetch_fields_t;

	// Raw address for the L2 side, split fields for the lookup
	typedef union packed {
		logic [`PC_LENGTH-1:0]  raw;
		fetch_fields_t          fields;
	} fetch_addr_u;

endpackage

//--- icache_refill_ctrl.sv
// Refill controller: detects a miss, requests the line from L2, gathers words and writes the victim way

`timescale 1ns/100ps

`include "icache_defines.svh"

module icache_refill_ctrl
(
	input  logic                     cache_clk,
	input  logic                     rst_n,
	input  icache_pkg::fetch_addr_u  pc,
	input  logic                     icache_hit,
	input  icache_pkg::way_mask_t    way_valid,
	input  logic                     update_valid,
	input  icache_pkg::word_sel_t    update_word,
	input  icache_pkg::inst_t        update_inst,
	output logic                     inst_update_req,
	output icache_pkg::fetch_addr_u  pc_up,
	output icache_pkg::index_t       index_up,
	output icache_pkg::tag_t         tag_up,
	output icache_pkg::inst_t        line_up [`ICACHE_WORDS],
	output icache_pkg::way_mask_t    way_wen
);

	import icache_pkg::*;

	localparam int RR_W = $clog2(`ICACHE_WAY);

	inst_t                     line_buf [`ICACHE_WORDS];
	logic [`ICACHE_WORDS-1:0]  recv_mask;
	logic [`ICACHE_WORDS-1:0]  recv_next;
	logic [`ICACHE_WORDS-1:0]  word_bit;
	logic [RR_W-1:0]           rr_ptr [`ICACHE_LINE];
	way_mask_t                 victim;
	logic                      miss;
	logic                      word_take;
	logic                      line_done;
	logic                      all_valid;

	// ======================================================================
	// Miss detection and word capture
	// ======================================================================
	assign miss      = !icache_hit && !inst_update_req;
	assign word_take = inst_update_req && update_valid;

	always_comb
	begin
		word_bit = '0;
		word_bit[update_word] = word_take;
	end

	assign recv_next = recv_mask | word_bit;
	assign line_done = word_take && (&recv_next);

	// Stored words plus the one arriving this cycle
	always_comb
	begin
		for (int w = 0; w < `ICACHE_WORDS; w++)
			line_up[w] = word_bit[w] ? update_inst : line_buf[w];
	end

	assign tag_up   = pc_up.fields.tag;
	assign index_up = pc_up.fields.index;

	// Idle/requesting state is the request level itself
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			inst_update_req <= 1'b0;
			recv_mask       <= '0;
		end
		else if (!inst_update_req)
		begin
			inst_update_req <= miss;
			recv_mask       <= '0;
		end
		else if (line_done)
		begin
			inst_update_req <= 1'b0;
			recv_mask       <= '0;
		end
		else
			recv_mask <= recv_next;
	end

	// Line-aligned refill address, frozen while requesting
	always_ff @(posedge cache_clk)
	begin
		if (miss)
		begin
			pc_up.fields.tag      <= pc.fields.tag;
			pc_up.fields.index    <= pc.fields.index;
			pc_up.fields.word     <= '0;
			pc_up.fields.byte_off <= '0;
		end
		if (word_take)
			line_buf[update_word] <= update_inst;
	end

	// ======================================================================
	// Victim choice
	// ======================================================================
	assign all_valid = &way_valid;

	// Lowest invalid way first, else the round-robin pointer
	always_comb
	begin
		victim = '0;
		if (all_valid)
			victim[rr_ptr[index_up]] = 1'b1;
		else
		begin
			for (int w = `ICACHE_WAY - 1; w >= 0; w--)
			begin
				if (!way_valid[w])
				begin
					victim    = '0;
					victim[w] = 1'b1;
				end
			end
		end
	end

	assign way_wen = line_done ? victim : '0;

	// Pointer moves only when a valid line was evicted
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int l = 0; l < `ICACHE_LINE; l++)
				rr_ptr[l] <= '0;
		end
		else if (line_done && all_valid)
		begin
			if (rr_ptr[index_up] == RR_W'(`ICACHE_WAY - 1))
				rr_ptr[index_up] <= '0;
			else
				rr_ptr[index_up] <= rr_ptr[index_up] + 1'b1;
		end
	end

endmodule

//--- icache_tb.sv
// Self-checking testbench for the instruction cache, run as the simulation top with the file list

`timescale 1ns/100ps

`include "icache_defines.svh"

module icache_tb;

	import icache_pkg::*;

	localparam int    FETCHES          = 4000;
	localparam int    CYCLES_PER_FETCH = 20;
	localparam int    CLK_PERIOD       = 100;
	localparam inst_t WORD_KEY         = 32'h5a3c_96e1;
	localparam tag_t  TAG_BASE         = tag_t'(24'h3a_5100);

	logic         cache_clk;
	logic         rst_n;
	fetch_addr_u  pc;
	logic         update_valid;
	word_sel_t    update_word;
	inst_t        update_inst;
	inst_t        inst_fetch;
	logic         icache_halt;
	logic         inst_update_req;
	fetch_addr_u  pc_up;

	// ======================================================================
	// Reference model and L2 responder state
	// ======================================================================
	logic                      m_valid [`ICACHE_WAY][`ICACHE_LINE];
	tag_t                      m_tag   [`ICACHE_WAY][`ICACHE_LINE];
	int                        m_rr    [`ICACHE_LINE];
	logic                      m_req;
	fetch_addr_u               m_addr;
	logic [`ICACHE_WORDS-1:0]  m_mask;
	int                        resp_delay;
	int                        resp_next;
	word_sel_t                 resp_order [`ICACHE_WORDS];
	int                        directed_tag [6] = '{0, 1, 2, 1, 0, 2};
	int                        mismatches = 0;
	int                        other_errors = 0;

	icache_top dut0
	(
		.cache_clk       (cache_clk),
		.rst_n           (rst_n),
		.pc              (pc),
		.update_valid    (update_valid),
		.update_word     (update_word),
		.update_inst     (update_inst),
		.inst_fetch      (inst_fetch),
		.icache_halt     (icache_halt),
		.inst_update_req (inst_update_req),
		.pc_up           (pc_up)
	);

	initial
	begin
		cache_clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) cache_clk = ~cache_clk;
	end

	task automatic check_inst(input string name, input inst_t got, input inst_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_addr(input string name, input fetch_addr_u got, input fetch_addr_u exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("mismatch %s: got %h expected %h at %0t", name, got.raw, exp.raw, $time);
		end
	endtask

	// L2 content is the word address XOR a key
	function automatic inst_t word_value(input fetch_addr_u addr);
		return {addr.raw[`PC_LENGTH-1:`BYTE_OFFSET], `BYTE_OFFSET'(0)} ^ WORD_KEY;
	endfunction

	// Way holding the address or -1 on a miss
	function automatic int model_way(input fetch_addr_u addr);
		for (int w = 0; w < `ICACHE_WAY; w++)
			if (m_valid[w][addr.fields.index] && m_tag[w][addr.fields.index] == addr.fields.tag)
				return w;
		return -1;
	endfunction

	// Opening fetches revisit one index with three tags, then 8 tags over all indices
	function automatic fetch_addr_u draw_pc(input int n);
		fetch_addr_u a;
		a.raw = $urandom;
		a.fields.tag = TAG_BASE + tag_t'($urandom_range(7));
		if (n < 6)
		begin
			a.fields.index = index_t'(5);
			a.fields.tag   = TAG_BASE + tag_t'(directed_tag[n]);
		end
		return a;
	endfunction

	// ======================================================================
	// Model update for the coming clock edge
	// ======================================================================
	task automatic model_advance();
		int        victim;
		int        j;
		index_t    idx;
		word_sel_t tmp;
		if (!m_req)
		begin
			if (model_way(pc) < 0)
			begin
				m_req  = 1'b1;
				m_mask = '0;
				m_addr = pc;
				m_addr.fields.word     = '0;
				m_addr.fields.byte_off = '0;
				resp_delay = $urandom_range(5, 1);
				resp_next  = 0;
				// Random word order for this line
				for (int w = 0; w < `ICACHE_WORDS; w++)
					resp_order[w] = word_sel_t'(w);
				for (int w = `ICACHE_WORDS - 1; w > 0; w--)
				begin
					j = $urandom_range(w);
					tmp = resp_order[w];
					resp_order[w] = resp_order[j];
					resp_order[j] = tmp;
				end
			end
		end
		else if (update_valid)
		begin
			m_mask[update_word] = 1'b1;
			if (&m_mask)
			begin
				idx = m_addr.fields.index;
				victim = -1;
				for (int w = `ICACHE_WAY - 1; w >= 0; w--)
					if (!m_valid[w][idx])
						victim = w;
				if (victim < 0)
				begin
					victim = m_rr[idx];
					m_rr[idx] = (m_rr[idx] + 1) % `ICACHE_WAY;
				end
				m_valid[victim][idx] = 1'b1;
				m_tag[victim][idx]   = m_addr.fields.tag;
				m_req = 1'b0;
			end
		end
	endtask

	// L2 words while requesting, stray strobes while idle
	task automatic drive_inputs();
		fetch_addr_u a;
		if (m_req)
		begin
			if (resp_delay > 0)
			begin
				resp_delay--;
				update_valid <= 1'b0;
			end
			else if (resp_next >= `ICACHE_WORDS || $urandom_range(2) == 0)
				update_valid <= 1'b0;
			else
			begin
				a = m_addr;
				a.fields.word = resp_order[resp_next];
				update_valid <= 1'b1;
				update_word  <= resp_order[resp_next];
				update_inst  <= word_value(a);
				resp_next++;
			end
			if ($urandom_range(15) == 0)
				pc <= draw_pc(FETCHES);
		end
		else
		begin
			update_valid <= ($urandom_range(3) == 0);
			update_word  <= word_sel_t'($urandom);
			update_inst  <= $urandom;
		end
	endtask

	task automatic run_cycle(output logic served);
		int way;
		@(negedge cache_clk);
		way = model_way(pc);
		check_flag("inst_update_req", inst_update_req, m_req);
		check_flag("icache_halt", icache_halt, way < 0);
		if (way >= 0)
			check_inst("inst_fetch", inst_fetch, word_value(pc));
		else
			check_inst("inst_fetch", inst_fetch, '0);
		if (m_req)
			check_addr("pc_up", pc_up, m_addr);
		served = !icache_halt;
		model_advance();
		@(posedge cache_clk);
		drive_inputs();
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial
	begin
		logic served;
		void'($urandom(66));
		for (int w = 0; w < `ICACHE_WAY; w++)
			for (int l = 0; l < `ICACHE_LINE; l++)
			begin
				m_valid[w][l] = 1'b0;
				m_tag[w][l]   = '0;
			end
		for (int l = 0; l < `ICACHE_LINE; l++)
			m_rr[l] = 0;
		m_req        = 1'b0;
		m_addr       = '0;
		m_mask       = '0;
		resp_delay   = 0;
		resp_next    = `ICACHE_WORDS;
		rst_n        = 1'b0;
		pc           = '0;
		update_valid = 1'b0;
		update_word  = '0;
		update_inst  = '0;
		repeat (2) @(posedge cache_clk);
		rst_n <= 1'b1;
		for (int n = 0; n < FETCHES; n++)
		begin
			pc <= draw_pc(n);
			served = 1'b0;
			while (!served)
				run_cycle(served);
		end
		$display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Watchdog sized from the fetch count
	initial
	begin
		#(CLK_PERIOD * (FETCHES * CYCLES_PER_FETCH + 2));
		other_errors++;
		$display("Timeout: the fetch stream did not complete in the allowed time");
		$display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- icache_top.sv
// Instruction cache top level wiring the refill controller, the ways and the way selector

`timescale 1ns/100ps

`include "icache_defines.svh"

module icache_top
(
	input  logic                     cache_clk,
	input  logic                     rst_n,
	input  icache_pkg::fetch_addr_u  pc,
	input  logic                     update_valid,
	input  icache_pkg::word_sel_t    update_word,
	input  icache_pkg::inst_t        update_inst,
	output icache_pkg::inst_t        inst_fetch,
	output logic                     icache_halt,
	output logic                     inst_update_req,
	output icache_pkg::fetch_addr_u  pc_up
);

	import icache_pkg::*;

	way_mask_t  way_valid;
	way_mask_t  way_hit;
	way_mask_t  way_wen;
	inst_t      way_inst [`ICACHE_WAY];
	inst_t      line_up  [`ICACHE_WORDS];
	index_t     index_up;
	tag_t       tag_up;
	logic       icache_hit;

	// ======================================================================
	// Refill controller
	// ======================================================================
	icache_refill_ctrl u_refill_ctrl
	(
		.cache_clk       (cache_clk),
		.rst_n           (rst_n),
		.pc              (pc),
		.icache_hit      (icache_hit),
		.way_valid       (way_valid),
		.update_valid    (update_valid),
		.update_word     (update_word),
		.update_inst     (update_inst),
		.inst_update_req (inst_update_req),
		.pc_up           (pc_up),
		.index_up        (index_up),
		.tag_up          (tag_up),
		.line_up         (line_up),
		.way_wen         (way_wen)
	);

	// ======================================================================
	// Ways
	// ======================================================================
	for (genvar w = 0; w < `ICACHE_WAY; w++)
	begin : g_way
		icache_way u_way
		(
			.cache_clk    (cache_clk),
			.rst_n        (rst_n),
			.pc           (pc),
			.index_up     (index_up),
			.tag_up       (tag_up),
			.line_up      (line_up),
			.wen          (way_wen[w]),
			.way_valid_up (way_valid[w]),
			.way_hit      (way_hit[w]),
			.way_inst     (way_inst[w])
		);
	end

	// Output merge
	icache_way_select u_way_select
	(
		.way_hit     (way_hit),
		.way_inst    (way_inst),
		.inst_fetch  (inst_fetch),
		.icache_hit  (icache_hit),
		.icache_halt (icache_halt)
	);

endmodule

//--- icache_way.sv
// One cache way with valid bits, tag and data arrays and the tag compare; instantiated per way

`timescale 1ns/100ps

`include "icache_defines.svh"

module icache_way
(
	input  logic                     cache_clk,
	input  logic                     rst_n,
	input  icache_pkg::fetch_addr_u  pc,
	input  icache_pkg::index_t       index_up,
	input  icache_pkg::tag_t         tag_up,
	input  icache_pkg::inst_t        line_up [`ICACHE_WORDS],
	input  logic                     wen,
	output logic                     way_valid_up,
	output logic                     way_hit,
	output icache_pkg::inst_t        way_inst
);

	import icache_pkg::*;

	// ======================================================================
	// Storage
	// ======================================================================
	logic [`ICACHE_LINE-1:0]  valid;
	tag_t                     tag_mem  [`ICACHE_LINE];
	inst_t                    data_mem [`ICACHE_LINE][`ICACHE_WORDS];

	// Lookup side, indexed by the fetch address
	index_t     rd_index;
	word_sel_t  rd_word;

	assign rd_index = pc.fields.index;
	assign rd_word  = pc.fields.word;

	// Valid bits are cleared on reset, set by a line write
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			valid <= '0;
		else if (wen)
			valid[index_up] <= 1'b1;
	end

	// Whole line and its tag go in on a single edge
	always_ff @(posedge cache_clk)
	begin
		if (wen)
		begin
			tag_mem[index_up] <= tag_up;
			for (int w = 0; w < `ICACHE_WORDS; w++)
				data_mem[index_up][w] <= line_up[w];
		end
	end

	// ======================================================================
	// Read and compare
	// ======================================================================

	// Valid at the refill index, for victim choice
	assign way_valid_up = valid[index_up];

	// Asynchronous read, hit only on a valid line
	assign way_hit  = valid[rd_index] && (tag_mem[rd_index] == pc.fields.tag);
	assign way_inst = data_mem[rd_index][rd_word];

endmodule

//--- icache_way_select.sv
// Way selector: merges the way hits into one instruction, the cache hit and the CPU halt

`timescale 1ns/100ps

`include "icache_defines.svh"

module icache_way_select
(
	input  icache_pkg::way_mask_t  way_hit,
	input  icache_pkg::inst_t      way_inst [`ICACHE_WAY],
	output icache_pkg::inst_t      inst_fetch,
	output logic                   icache_hit,
	output logic                   icache_halt
);

	import icache_pkg::*;

	// ======================================================================
	// Instruction mux
	// ======================================================================

	// Only a single hitting way drives the output, zero otherwise
	always_comb
	begin
		inst_fetch = '0;
		for (int w = 0; w < `ICACHE_WAY; w++)
		begin
			if (way_hit == (way_mask_t'(1) << w))
				inst_fetch = way_inst[w];
		end
	end

	// Hit and halt
	assign icache_hit  = |way_hit;
	assign icache_halt = !icache_hit;

endmodule

//--- verilog.f
+incdir+.
icache_pkg.sv
icache_way.sv
icache_refill_ctrl.sv
icache_way_select.sv
icache_top.sv
icache_tb.sv
